//--- common/back_end_pkg.sv
`default_nettype none

package back_end_pkg;

	localparam int DATA_W = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS = 2 ** REG_ADDR_W;
	localparam int CSR_ADDR_W = 2;
	localparam int NUM_CSRS = 2 ** CSR_ADDR_W;
	localparam int MAX_WARPS = 8;

	// Ceiling log2, at least one bit
	function automatic int log2(input int value);
		int width;
		width = 1;
		while ((2 ** width) < value) begin
			width = width + 1;
		end
		return width;
	endfunction

	localparam int WARP_PORT_W = log2(MAX_WARPS);

	typedef logic [WARP_PORT_W-1:0] warp_t;

	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_AND   = 4'd2,
		OP_OR    = 4'd3,
		OP_XOR   = 4'd4,
		OP_SLT   = 4'd5,
		OP_BEQ   = 4'd6,
		OP_BNE   = 4'd7,
		OP_JAL   = 4'd8,
		OP_LW    = 4'd9,
		OP_SW    = 4'd10,
		OP_CSRRW = 4'd11
	} op_e;

	typedef enum logic [1:0] {
		UNIT_EXEC = 2'd0,
		UNIT_LSU  = 2'd1,
		UNIT_CSR  = 2'd2
	} unit_e;

	typedef struct packed {
		logic                  valid;
		warp_t                 warp;
		logic [DATA_W-1:0]     pc;
		op_e                   op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [DATA_W-1:0]     imm;
		logic [CSR_ADDR_W-1:0] csr_addr;
	} issue_req_t;

	typedef struct packed {
		logic                  valid;
		warp_t                 warp;
		logic [DATA_W-1:0]     pc;
		op_e                   op;
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0]     rs1_data;
		logic [DATA_W-1:0]     rs2_data;
		logic [DATA_W-1:0]     imm;
		logic [CSR_ADDR_W-1:0] csr_addr;
	} unit_req_t;

	typedef struct packed {
		logic                  valid;
		warp_t                 warp;
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0]     data;
	} wb_t;

	typedef struct packed {
		logic              valid;
		warp_t             warp;
		logic              taken;
		logic [DATA_W-1:0] dest;
	} branch_rsp_t;

	typedef struct packed {
		logic              valid;
		warp_t             warp;
		logic [DATA_W-1:0] dest;
	} jal_rsp_t;

	typedef struct packed {
		logic              valid;
		logic              write;
		logic [DATA_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} dcache_req_t;

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] data;
	} dcache_rsp_t;

endpackage

`default_nettype wire

//--- rtl/gpr_stage.sv
`timescale 1ns/100ps
`default_nettype none

module gpr_stage #(
	parameter int NUM_WARPS = 4
) (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       schedule_delay,
	input  back_end_pkg::issue_req_t  issue,
	input  back_end_pkg::wb_t         writeback_in,
	input  wire                       mem_delay,
	input  wire                       exec_delay,
	input  wire                       stall_gpr_csr,
	output back_end_pkg::unit_req_t   exec_req,
	output back_end_pkg::unit_req_t   lsu_req,
	output back_end_pkg::unit_req_t   csr_req,
	output logic                      gpr_stage_delay
);

	localparam int WARP_W = back_end_pkg::log2(NUM_WARPS);

	logic [back_end_pkg::DATA_W-1:0] regs [NUM_WARPS][back_end_pkg::NUM_REGS];

	back_end_pkg::unit_req_t req_q;
	back_end_pkg::unit_e     unit_q;
	back_end_pkg::unit_e     unit_d;
	logic                    target_busy;
	logic                    accept;
	logic [back_end_pkg::DATA_W-1:0] rs1_data;
	logic [back_end_pkg::DATA_W-1:0] rs2_data;

	always_comb begin
		case (issue.op)
			back_end_pkg::OP_LW, back_end_pkg::OP_SW: unit_d = back_end_pkg::UNIT_LSU;
			back_end_pkg::OP_CSRRW:                   unit_d = back_end_pkg::UNIT_CSR;
			default:                                  unit_d = back_end_pkg::UNIT_EXEC;
		endcase
	end

	// Write-through from the writeback port, r0 reads zero
	function automatic logic [back_end_pkg::DATA_W-1:0] read_reg(
		input logic [back_end_pkg::REG_ADDR_W-1:0] idx,
		input logic [back_end_pkg::DATA_W-1:0]     stored
	);
		if (idx == '0)
			return '0;
		if (writeback_in.valid && writeback_in.warp == issue.warp && writeback_in.rd == idx)
			return writeback_in.data;
		return stored;
	endfunction

	assign rs1_data = read_reg(issue.rs1, regs[issue.warp[WARP_W-1:0]][issue.rs1]);
	assign rs2_data = read_reg(issue.rs2, regs[issue.warp[WARP_W-1:0]][issue.rs2]);

	always_comb begin
		case (unit_q)
			back_end_pkg::UNIT_EXEC: target_busy = exec_delay;
			back_end_pkg::UNIT_LSU:  target_busy = mem_delay;
			default:                 target_busy = 1'b0;
		endcase
	end

	assign gpr_stage_delay = stall_gpr_csr || (req_q.valid && target_busy);
	assign accept = issue.valid && !schedule_delay && !gpr_stage_delay;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < NUM_WARPS; w++) begin
				for (int r = 0; r < back_end_pkg::NUM_REGS; r++) begin
					regs[w][r] <= '0;
				end
			end
		end else if (writeback_in.valid && writeback_in.rd != '0) begin
			regs[writeback_in.warp[WARP_W-1:0]][writeback_in.rd] <= writeback_in.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			req_q.valid <= 1'b0;
			unit_q      <= back_end_pkg::UNIT_EXEC;
		end else if (!gpr_stage_delay) begin
			req_q <= '{valid: accept, warp: issue.warp, pc: issue.pc, op: issue.op,
				rd: issue.rd, rs1_data: rs1_data, rs2_data: rs2_data, imm: issue.imm,
				csr_addr: issue.csr_addr};
			unit_q <= unit_d;
		end
	end

	always_comb begin
		exec_req = req_q;
		lsu_req  = req_q;
		csr_req  = req_q;
		exec_req.valid = req_q.valid && !gpr_stage_delay && unit_q == back_end_pkg::UNIT_EXEC;
		lsu_req.valid  = req_q.valid && !gpr_stage_delay && unit_q == back_end_pkg::UNIT_LSU;
		csr_req.valid  = req_q.valid && !gpr_stage_delay && unit_q == back_end_pkg::UNIT_CSR;
	end

endmodule

`default_nettype wire

//--- rtl/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
	input  wire                        clk,
	input  wire                        reset,
	input  back_end_pkg::unit_req_t    exec_req,
	input  wire                        no_slot_exec,
	output back_end_pkg::wb_t          exec_wb,
	output back_end_pkg::branch_rsp_t  branch_rsp,
	output back_end_pkg::jal_rsp_t     jal_rsp,
	output logic                       exec_delay
);

	logic [back_end_pkg::DATA_W-1:0] result;
	logic [back_end_pkg::DATA_W-1:0] target;
	logic                            writes_rd;
	logic                            is_branch;
	logic                            is_jal;
	logic                            equal;
	logic                            less;

	assign target = exec_req.pc + exec_req.imm;
	assign equal  = exec_req.rs1_data == exec_req.rs2_data;
	assign less   = $signed(exec_req.rs1_data) < $signed(exec_req.rs2_data);

	assign is_branch = exec_req.op == back_end_pkg::OP_BEQ || exec_req.op == back_end_pkg::OP_BNE;
	assign is_jal    = exec_req.op == back_end_pkg::OP_JAL;
	assign writes_rd = !is_branch;

	always_comb begin
		case (exec_req.op)
			back_end_pkg::OP_ADD: result = exec_req.rs1_data + exec_req.rs2_data;
			back_end_pkg::OP_SUB: result = exec_req.rs1_data - exec_req.rs2_data;
			back_end_pkg::OP_AND: result = exec_req.rs1_data & exec_req.rs2_data;
			back_end_pkg::OP_OR:  result = exec_req.rs1_data | exec_req.rs2_data;
			back_end_pkg::OP_XOR: result = exec_req.rs1_data ^ exec_req.rs2_data;
			back_end_pkg::OP_SLT: result = {{(back_end_pkg::DATA_W-1){1'b0}}, less};
			// Link value
			back_end_pkg::OP_JAL: result = exec_req.pc + 32'd4;
			default:              result = '0;
		endcase
	end

	// Refused result stays put
	assign exec_delay = exec_wb.valid && no_slot_exec;

	always_ff @(posedge clk) begin
		if (reset) begin
			exec_wb.valid <= 1'b0;
		end else if (!exec_delay) begin
			exec_wb <= '{valid: exec_req.valid && writes_rd, warp: exec_req.warp,
				rd: exec_req.rd, data: result};
		end
	end

	// Control flow responses bypass writeback
	always_ff @(posedge clk) begin
		if (reset) begin
			branch_rsp.valid <= 1'b0;
			jal_rsp.valid    <= 1'b0;
		end else begin
			branch_rsp <= '{valid: exec_req.valid && is_branch, warp: exec_req.warp,
				taken: (exec_req.op == back_end_pkg::OP_BEQ) ? equal : !equal, dest: target};
			jal_rsp <= '{valid: exec_req.valid && is_jal, warp: exec_req.warp, dest: target};
		end
	end

endmodule

`default_nettype wire

//--- rtl/lsu.sv
`timescale 1ns/100ps
`default_nettype none

module lsu (
	input  wire                        clk,
	input  wire                        reset,
	input  back_end_pkg::unit_req_t    lsu_req,
	input  back_end_pkg::dcache_rsp_t  dcache_rsp,
	input  wire                        no_slot_mem,
	output back_end_pkg::dcache_req_t  dcache_req,
	output back_end_pkg::wb_t          mem_wb,
	output logic                       mem_delay
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_RSP,
		HOLD_WB
	} state_e;

	state_e                                state_q;
	logic                                  write_q;
	back_end_pkg::warp_t                   warp_q;
	logic [back_end_pkg::REG_ADDR_W-1:0]   rd_q;
	logic [back_end_pkg::DATA_W-1:0]       data_q;

	assign mem_delay = state_q != IDLE;

	assign mem_wb = '{valid: state_q == HOLD_WB, warp: warp_q, rd: rd_q, data: data_q};

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q          <= IDLE;
			dcache_req.valid <= 1'b0;
		end else begin
			// Request is a single-cycle strobe
			dcache_req.valid <= 1'b0;
			case (state_q)
				IDLE: begin
					if (lsu_req.valid) begin
						dcache_req <= '{valid: 1'b1,
							write: lsu_req.op == back_end_pkg::OP_SW,
							addr: lsu_req.rs1_data + lsu_req.imm, data: lsu_req.rs2_data};
						write_q <= lsu_req.op == back_end_pkg::OP_SW;
						warp_q  <= lsu_req.warp;
						rd_q    <= lsu_req.rd;
						state_q <= WAIT_RSP;
					end
				end
				WAIT_RSP: begin
					if (dcache_rsp.valid) begin
						data_q  <= dcache_rsp.data;
						// Stores complete here with no writeback
						state_q <= write_q ? IDLE : HOLD_WB;
					end
				end
				HOLD_WB: begin
					if (!no_slot_mem)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/csr_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module csr_pipe (
	input  wire                      clk,
	input  wire                      reset,
	input  back_end_pkg::unit_req_t  csr_req,
	input  wire                      no_slot_csr,
	output back_end_pkg::wb_t        csr_wb,
	output logic                     stall_gpr_csr
);

	logic [back_end_pkg::DATA_W-1:0] csr_regs [back_end_pkg::NUM_CSRS];
	back_end_pkg::wb_t               stage_q;

	assign stall_gpr_csr = stage_q.valid || csr_wb.valid;

	// Swap on dispatch, old value goes down the pipe
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < back_end_pkg::NUM_CSRS; i++) begin
				csr_regs[i] <= '0;
			end
			stage_q.valid <= 1'b0;
		end else begin
			stage_q <= '{valid: csr_req.valid, warp: csr_req.warp, rd: csr_req.rd,
				data: csr_regs[csr_req.csr_addr]};
			if (csr_req.valid)
				csr_regs[csr_req.csr_addr] <= csr_req.rs1_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			csr_wb.valid <= 1'b0;
		end else if (!(csr_wb.valid && no_slot_csr)) begin
			csr_wb <= stage_q;
		end
	end

endmodule

`default_nettype wire

//--- rtl/writeback.sv
`timescale 1ns/100ps
`default_nettype none

module writeback (
	input  wire                clk,
	input  wire                reset,
	input  back_end_pkg::wb_t  mem_wb,
	input  back_end_pkg::wb_t  exec_wb,
	input  back_end_pkg::wb_t  csr_wb,
	output back_end_pkg::wb_t  writeback_out,
	output logic               no_slot_mem,
	output logic               no_slot_exec,
	output logic               no_slot_csr
);

	logic [2:0]        valid_vec;
	logic [2:0]        grant;
	back_end_pkg::wb_t selected;

	// Bit 0 wins, so lsu has top priority
	assign valid_vec = {csr_wb.valid, exec_wb.valid, mem_wb.valid};
	assign grant     = valid_vec & (~valid_vec + 3'd1);

	assign no_slot_mem  = valid_vec[0] && !grant[0];
	assign no_slot_exec = valid_vec[1] && !grant[1];
	assign no_slot_csr  = valid_vec[2] && !grant[2];

	always_comb begin
		selected = '0;
		if (grant[0])
			selected = mem_wb;
		else if (grant[1])
			selected = exec_wb;
		else if (grant[2])
			selected = csr_wb;
	end

	always_ff @(posedge clk) begin
		if (reset)
			writeback_out.valid <= 1'b0;
		else
			writeback_out <= selected;
	end

endmodule

`default_nettype wire

//--- rtl/back_end.sv
`timescale 1ns/100ps
`default_nettype none

module back_end #(
	parameter int NUM_WARPS = 4
) (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        schedule_delay,
	input  back_end_pkg::issue_req_t   issue,
	input  back_end_pkg::dcache_rsp_t  dcache_rsp,
	output back_end_pkg::dcache_req_t  dcache_req,
	output logic                       out_mem_delay,
	output logic                       out_exec_delay,
	output logic                       gpr_stage_delay,
	output back_end_pkg::jal_rsp_t     jal_rsp,
	output back_end_pkg::branch_rsp_t  branch_rsp,
	output back_end_pkg::wb_t          writeback_out
);

	back_end_pkg::unit_req_t exec_req;
	back_end_pkg::unit_req_t lsu_req;
	back_end_pkg::unit_req_t csr_req;
	back_end_pkg::wb_t       exec_wb;
	back_end_pkg::wb_t       mem_wb;
	back_end_pkg::wb_t       csr_wb;
	logic                    stall_gpr_csr;
	logic                    no_slot_mem;
	logic                    no_slot_exec;
	logic                    no_slot_csr;

	gpr_stage #(
		.NUM_WARPS(NUM_WARPS)
	) i_gpr_stage (
		.clk            (clk),
		.reset          (reset),
		.schedule_delay (schedule_delay),
		.issue          (issue),
		.writeback_in   (writeback_out),
		.mem_delay      (out_mem_delay),
		.exec_delay     (out_exec_delay),
		.stall_gpr_csr  (stall_gpr_csr),
		.exec_req       (exec_req),
		.lsu_req        (lsu_req),
		.csr_req        (csr_req),
		.gpr_stage_delay(gpr_stage_delay)
	);

	execute_unit i_execute_unit (
		.clk         (clk),
		.reset       (reset),
		.exec_req    (exec_req),
		.no_slot_exec(no_slot_exec),
		.exec_wb     (exec_wb),
		.branch_rsp  (branch_rsp),
		.jal_rsp     (jal_rsp),
		.exec_delay  (out_exec_delay)
	);

	lsu i_lsu (
		.clk        (clk),
		.reset      (reset),
		.lsu_req    (lsu_req),
		.dcache_rsp (dcache_rsp),
		.no_slot_mem(no_slot_mem),
		.dcache_req (dcache_req),
		.mem_wb     (mem_wb),
		.mem_delay  (out_mem_delay)
	);

	csr_pipe i_csr_pipe (
		.clk          (clk),
		.reset        (reset),
		.csr_req      (csr_req),
		.no_slot_csr  (no_slot_csr),
		.csr_wb       (csr_wb),
		.stall_gpr_csr(stall_gpr_csr)
	);

	writeback i_writeback (
		.clk          (clk),
		.reset        (reset),
		.mem_wb       (mem_wb),
		.exec_wb      (exec_wb),
		.csr_wb       (csr_wb),
		.writeback_out(writeback_out),
		.no_slot_mem  (no_slot_mem),
		.no_slot_exec (no_slot_exec),
		.no_slot_csr  (no_slot_csr)
	);

endmodule

`default_nettype wire

//--- verif/back_end_tb.sv
`timescale 1ns/100ps
`default_nettype none

module back_end_tb;

	localparam int NUM_WARPS = 4;
	localparam int MAX_LATENCY = 5;
	localparam int CLK_PERIOD = 20;
	// Seed JALs, arithmetic, r0 reads, stream, branches, memory, CSR, contention
	localparam int NUM_INSTR = 60 + 48 + 4 + 16 + 16 + 12 + 12 + 12;

	logic                      clk;
	logic                      reset;
	logic                      schedule_delay;
	back_end_pkg::issue_req_t  issue;
	back_end_pkg::dcache_rsp_t dcache_rsp;
	back_end_pkg::dcache_req_t dcache_req;
	logic                      out_mem_delay;
	logic                      out_exec_delay;
	logic                      gpr_stage_delay;
	back_end_pkg::jal_rsp_t    jal_rsp;
	back_end_pkg::branch_rsp_t branch_rsp;
	back_end_pkg::wb_t         writeback_out;

	integer seed = 32'h0d2d963b;
	int     fixed_latency;
	logic   no_stall_allowed;
	logic   exec_refused;
	event   checked;

	logic [31:0] ref_regs [NUM_WARPS][32];
	logic [31:0] ref_csrs [4];
	logic [31:0] ref_mem [logic [31:0]];
	logic [31:0] cache_mem [logic [31:0]];

	back_end_pkg::wb_t         exp_wb [$];
	back_end_pkg::branch_rsp_t exp_branch [$];
	back_end_pkg::jal_rsp_t    exp_jal [$];
	back_end_pkg::dcache_req_t exp_dcache [$];

	back_end #(
		.NUM_WARPS(NUM_WARPS)
	) i_back_end (
		.clk            (clk),
		.reset          (reset),
		.schedule_delay (schedule_delay),
		.issue          (issue),
		.dcache_rsp     (dcache_rsp),
		.dcache_req     (dcache_req),
		.out_mem_delay  (out_mem_delay),
		.out_exec_delay (out_exec_delay),
		.gpr_stage_delay(gpr_stage_delay),
		.jal_rsp        (jal_rsp),
		.branch_rsp     (branch_rsp),
		.writeback_out  (writeback_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic compare_wb(input back_end_pkg::wb_t actual, input back_end_pkg::wb_t expected);
		if (actual !== expected) begin
			$display("Error: writeback_out expected %h, got %h", expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic compare_branch(input back_end_pkg::branch_rsp_t actual,
		input back_end_pkg::branch_rsp_t expected);
		if (actual !== expected) begin
			$display("Error: branch_rsp expected %h, got %h", expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic compare_jal(input back_end_pkg::jal_rsp_t actual,
		input back_end_pkg::jal_rsp_t expected);
		if (actual !== expected) begin
			$display("Error: jal_rsp expected %h, got %h", expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic compare_dcache(input back_end_pkg::dcache_req_t actual,
		input back_end_pkg::dcache_req_t expected);
		if (actual !== expected) begin
			$display("Error: dcache_req expected %h, got %h", expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_mem_busy();
		if (out_mem_delay !== 1'b1) begin
			$display("Error: out_mem_delay expected %h, got %h", 1'b1, out_mem_delay);
			stop_with_failure();
		end
	endtask

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	function automatic int pick(input int n);
		return next_random() % n;
	endfunction

	// Architectural model, updated in issue order
	function automatic void ref_execute(input back_end_pkg::issue_req_t req,
		output back_end_pkg::wb_t wb, output back_end_pkg::branch_rsp_t br,
		output back_end_pkg::jal_rsp_t jl, output back_end_pkg::dcache_req_t mem);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		a = (req.rs1 == 0) ? 32'd0 : ref_regs[req.warp][req.rs1];
		b = (req.rs2 == 0) ? 32'd0 : ref_regs[req.warp][req.rs2];
		addr = a + req.imm;
		wb = '{valid: 1'b1, warp: req.warp, rd: req.rd, data: 32'd0};
		br = '{valid: 1'b0, warp: req.warp, taken: 1'b0, dest: req.pc + req.imm};
		jl = '{valid: 1'b0, warp: req.warp, dest: req.pc + req.imm};
		mem = '{valid: 1'b0, write: 1'b0, addr: addr, data: b};
		case (req.op)
			back_end_pkg::OP_ADD: wb.data = a + b;
			back_end_pkg::OP_SUB: wb.data = a - b;
			back_end_pkg::OP_AND: wb.data = a & b;
			back_end_pkg::OP_OR:  wb.data = a | b;
			back_end_pkg::OP_XOR: wb.data = a ^ b;
			back_end_pkg::OP_SLT: wb.data = {31'd0, $signed(a) < $signed(b)};
			back_end_pkg::OP_BEQ, back_end_pkg::OP_BNE: begin
				wb.valid = 1'b0;
				br.valid = 1'b1;
				br.taken = (a == b) == (req.op == back_end_pkg::OP_BEQ);
			end
			back_end_pkg::OP_JAL: begin
				wb.data = req.pc + 32'd4;
				jl.valid = 1'b1;
			end
			back_end_pkg::OP_LW: begin
				mem.valid = 1'b1;
				wb.data = ref_mem.exists(addr) ? ref_mem[addr] : 32'd0;
			end
			back_end_pkg::OP_SW: begin
				wb.valid = 1'b0;
				mem.valid = 1'b1;
				mem.write = 1'b1;
				ref_mem[addr] = b;
			end
			back_end_pkg::OP_CSRRW: begin
				wb.data = ref_csrs[req.csr_addr];
				ref_csrs[req.csr_addr] = a;
			end
			default: wb.valid = 1'b0;
		endcase
		if (wb.valid && req.rd != 0)
			ref_regs[req.warp][req.rd] = wb.data;
	endfunction

	function automatic back_end_pkg::issue_req_t make_instr(input back_end_pkg::op_e op,
		input int warp, input int rd, input int rs1, input int rs2, input logic [31:0] imm);
		back_end_pkg::issue_req_t req;
		req.valid    = 1'b1;
		req.warp     = back_end_pkg::warp_t'(warp);
		req.pc       = next_random() & 32'hffff_fffc;
		req.op       = op;
		req.rd       = 5'(rd);
		req.rs1      = 5'(rs1);
		req.rs2      = 5'(rs2);
		req.imm      = imm;
		req.csr_addr = 2'(pick(4));
		return req;
	endfunction

	// Hold is the number of cycles schedule_delay blocks the request
	task automatic send_instr(input back_end_pkg::issue_req_t req, input int hold);
		back_end_pkg::wb_t         wb;
		back_end_pkg::branch_rsp_t br;
		back_end_pkg::jal_rsp_t    jl;
		back_end_pkg::dcache_req_t mem;
		issue = req;
		schedule_delay = hold > 0;
		repeat (hold) @(negedge clk);
		schedule_delay = 1'b0;
		while (gpr_stage_delay) begin
			@(negedge clk);
		end
		ref_execute(req, wb, br, jl, mem);
		if (wb.valid)
			exp_wb.push_back(wb);
		if (br.valid)
			exp_branch.push_back(br);
		if (jl.valid)
			exp_jal.push_back(jl);
		if (mem.valid)
			exp_dcache.push_back(mem);
		@(negedge clk);
		issue.valid = 1'b0;
	endtask

	task automatic wait_idle();
		repeat (2) @(checked);
		while (exp_wb.size() != 0 || exp_branch.size() != 0 || exp_jal.size() != 0
			|| exp_dcache.size() != 0 || out_mem_delay || out_exec_delay || gpr_stage_delay) begin
			@(checked);
		end
	endtask

	task automatic run_instr(input back_end_pkg::issue_req_t req);
		send_instr(req, 0);
		wait_idle();
	endtask

	initial begin
		forever begin
			@(negedge clk);
			if (writeback_out.valid === 1'b1) begin
				if (exp_wb.size() == 0) begin
					$display("A writeback arrived that no instruction should produce");
					stop_with_failure();
				end else begin
					compare_wb(writeback_out, exp_wb.pop_front());
				end
			end
			if (branch_rsp.valid === 1'b1) begin
				if (exp_branch.size() == 0) begin
					$display("A branch response arrived with no branch outstanding");
					stop_with_failure();
				end else begin
					compare_branch(branch_rsp, exp_branch.pop_front());
				end
			end
			if (jal_rsp.valid === 1'b1) begin
				if (exp_jal.size() == 0) begin
					$display("A jump response arrived with no jump outstanding");
					stop_with_failure();
				end else begin
					compare_jal(jal_rsp, exp_jal.pop_front());
				end
			end
			if (no_stall_allowed && gpr_stage_delay !== 1'b0) begin
				$display("Error: gpr_stage_delay expected %h, got %h", 1'b0, gpr_stage_delay);
				stop_with_failure();
			end
			if (out_exec_delay === 1'b1)
				exec_refused = 1'b1;
			->checked;
		end
	end

	// Data cache with variable response latency
	initial begin
		int                        latency;
		back_end_pkg::dcache_req_t req_seen;
		forever begin
			@(negedge clk);
			if (dcache_req.valid === 1'b1) begin
				req_seen = dcache_req;
				if (exp_dcache.size() == 0) begin
					$display("A data-cache request arrived with no memory instruction outstanding");
					stop_with_failure();
				end else begin
					compare_dcache(req_seen, exp_dcache.pop_front());
				end
				latency = (fixed_latency >= 0) ? fixed_latency : pick(MAX_LATENCY + 1);
				check_mem_busy();
				repeat (latency) begin
					@(negedge clk);
					check_mem_busy();
				end
				if (req_seen.write)
					cache_mem[req_seen.addr] = req_seen.data;
				else if (cache_mem.exists(req_seen.addr))
					dcache_rsp.data = cache_mem[req_seen.addr];
				else
					dcache_rsp.data = '0;
				dcache_rsp.valid = 1'b1;
				@(negedge clk);
				dcache_rsp.valid = 1'b0;
			end
		end
	end

	initial begin
		#(NUM_INSTR * (10 + MAX_LATENCY) * CLK_PERIOD + 5 * CLK_PERIOD);
		$display("Timeout: the DUT did not complete all instructions in time");
		stop_with_failure();
	end

	initial begin
		back_end_pkg::issue_req_t req;
		logic [31:0]              stored_addr [6];
		int                       warp;
		int                       rs1;
		reset = 1'b1;
		schedule_delay = 1'b0;
		issue = '0;
		dcache_rsp = '0;
		fixed_latency = -1;
		no_stall_allowed = 1'b0;
		exec_refused = 1'b0;
		for (int w = 0; w < NUM_WARPS; w++) begin
			for (int r = 0; r < 32; r++) begin
				ref_regs[w][r] = '0;
			end
		end
		for (int c = 0; c < 4; c++) begin
			ref_csrs[c] = '0;
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// Jump-and-link fills registers 1 to 15 of every warp
		for (int w = 0; w < NUM_WARPS; w++) begin
			for (int r = 1; r < 16; r++) begin
				run_instr(make_instr(back_end_pkg::OP_JAL, w, r, 0, 0, next_random()));
			end
		end

		// Every fourth result goes to r0
		for (int k = 0; k < 6; k++) begin
			for (int i = 0; i < 8; i++) begin
				run_instr(make_instr(back_end_pkg::op_e'(k), pick(NUM_WARPS),
					(i % 4 == 0) ? 0 : pick(32), pick(32), pick(32), 32'd0));
			end
		end
		for (int w = 0; w < NUM_WARPS; w++) begin
			run_instr(make_instr(back_end_pkg::OP_OR, w, 0, 0, 0, 32'd0));
		end

		// Stream reads r1-r15 and writes r16-r31 so nothing depends on in-flight results
		no_stall_allowed = 1'b1;
		for (int i = 0; i < 16; i++) begin
			send_instr(make_instr(back_end_pkg::op_e'(pick(6)), pick(NUM_WARPS),
				16 + pick(16), 1 + pick(15), 1 + pick(15), 32'd0), 0);
		end
		wait_idle();
		no_stall_allowed = 1'b0;

		for (int i = 0; i < 16; i++) begin
			rs1 = pick(32);
			req = make_instr((i % 2 == 1) ? back_end_pkg::OP_BNE : back_end_pkg::OP_BEQ,
				pick(NUM_WARPS), pick(32), rs1, (i % 4 < 2) ? rs1 : pick(32), next_random());
			run_instr(req);
		end

		for (int i = 0; i < 6; i++) begin
			stored_addr[i] = next_random() & 32'hffff_fffc;
			warp = pick(NUM_WARPS);
			run_instr(make_instr(back_end_pkg::OP_SW, warp, 0, 0, 1 + pick(15), stored_addr[i]));
			run_instr(make_instr(back_end_pkg::OP_LW, (warp + 1) % NUM_WARPS, 1 + pick(31), 0, 0,
				stored_addr[i]));
		end

		for (int i = 0; i < 12; i++) begin
			run_instr(make_instr(back_end_pkg::OP_CSRRW, pick(NUM_WARPS), 1 + pick(31),
				1 + pick(31), 0, 32'd0));
		end

		// Zero latency lines the load result up with the next ALU result
		fixed_latency = 0;
		for (int i = 0; i < 4; i++) begin
			warp = pick(NUM_WARPS);
			exec_refused = 1'b0;
			send_instr(make_instr(back_end_pkg::OP_LW, warp, 16 + pick(16), 0, 0,
				stored_addr[i]), 0);
			send_instr(make_instr(back_end_pkg::op_e'(pick(6)), (warp + 1) % NUM_WARPS,
				16 + pick(16), 1 + pick(15), 1 + pick(15), 32'd0), 0);
			wait_idle();
			if (!exec_refused) begin
				$display("The ALU result was never held back behind the load result");
				stop_with_failure();
			end
			send_instr(make_instr(back_end_pkg::OP_ADD, pick(NUM_WARPS), 1 + pick(31),
				pick(32), pick(32), 32'd0), 1 + pick(3));
			wait_idle();
		end
		fixed_latency = -1;

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
common/back_end_pkg.sv
rtl/gpr_stage.sv
rtl/execute_unit.sv
rtl/lsu.sv
rtl/csr_pipe.sv
rtl/writeback.sv
rtl/back_end.sv
verif/back_end_tb.sv

//--- Bender.yml
package:
  name: back_end

sources:
  - files:
      - common/back_end_pkg.sv
      - rtl/gpr_stage.sv
      - rtl/execute_unit.sv
      - rtl/lsu.sv
      - rtl/csr_pipe.sv
      - rtl/writeback.sv
      - rtl/back_end.sv
  - target: test
    files:
      - verif/back_end_tb.sv
